// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_bridge_tb -f src.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build error"
    exit 1
fi

out=$(./obj_dir/Vmem_bridge_tb +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1

// File: source/axi_port_arbiter.sv
// two-master AXI arbiter with latched read and write grants and ID-routed read data
module axi_port_arbiter #(
    parameter sramx_pkg::axi_id_t ID_A = 4'd0,
    parameter sramx_pkg::axi_id_t ID_B = 4'd1
) (
    input  logic                   clk,
    input  logic                   arst_n,

    // slave sides a and b
    input  sramx_pkg::axi_id_t     arid_a, arid_b,
    input  sramx_pkg::word_t       araddr_a, araddr_b,
    input  sramx_pkg::axi_len_t    arlen_a, arlen_b,
    input  sramx_pkg::axi_size_t   arsize_a, arsize_b,
    input  sramx_pkg::axi_burst_t  arburst_a, arburst_b,
    input  logic                   arvalid_a, arvalid_b,
    output logic                   arready_a, arready_b,
    output sramx_pkg::word_t       rdata_axi_a, rdata_axi_b,
    output logic                   rvalid_a, rvalid_b,
    output logic                   rlast_a, rlast_b,
    input  logic                   rready_a, rready_b,
    input  sramx_pkg::axi_id_t     awid_a, awid_b,
    input  sramx_pkg::word_t       awaddr_a, awaddr_b,
    input  sramx_pkg::axi_len_t    awlen_a, awlen_b,
    input  sramx_pkg::axi_size_t   awsize_a, awsize_b,
    input  sramx_pkg::axi_burst_t  awburst_a, awburst_b,
    input  logic                   awvalid_a, awvalid_b,
    output logic                   awready_a, awready_b,
    input  sramx_pkg::word_t       wdata_axi_a, wdata_axi_b,
    input  sramx_pkg::axi_strb_t   wstrb_a, wstrb_b,
    input  logic                   wlast_a, wlast_b,
    input  logic                   wvalid_a, wvalid_b,
    output logic                   wready_a, wready_b,
    output logic                   bvalid_a, bvalid_b,
    input  logic                   bready_a, bready_b,

    // master side
    output sramx_pkg::axi_id_t     arid,
    output sramx_pkg::word_t       araddr,
    output sramx_pkg::axi_len_t    arlen,
    output sramx_pkg::axi_size_t   arsize,
    output sramx_pkg::axi_burst_t  arburst,
    output logic                   arvalid,
    input  logic                   arready,
    input  sramx_pkg::axi_id_t     rid,
    input  sramx_pkg::word_t       rdata_axi,
    input  logic                   rvalid,
    input  logic                   rlast,
    output logic                   rready,
    output sramx_pkg::axi_id_t     awid,
    output sramx_pkg::word_t       awaddr,
    output sramx_pkg::axi_len_t    awlen,
    output sramx_pkg::axi_size_t   awsize,
    output sramx_pkg::axi_burst_t  awburst,
    output logic                   awvalid,
    input  logic                   awready,
    output sramx_pkg::word_t       wdata_axi,
    output sramx_pkg::axi_strb_t   wstrb,
    output logic                   wlast,
    output logic                   wvalid,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready
);
    logic rd_busy;
    logic rd_sel;
    logic rd_prio;
    logic rd_gnt;
    logic wr_busy;
    logic wr_sel;
    logic wr_prio;
    logic wr_gnt;
    logic wr_req_a;
    logic wr_req_b;
    logic r_to_a;
    logic r_to_b;

    // grant: 0 selects a, 1 selects b
    assign rd_gnt = rd_busy ? rd_sel : ((arvalid_a && arvalid_b) ? rd_prio : arvalid_b);

    assign wr_req_a = awvalid_a || wvalid_a;
    assign wr_req_b = awvalid_b || wvalid_b;
    assign wr_gnt   = wr_busy ? wr_sel : ((wr_req_a && wr_req_b) ? wr_prio : wr_req_b);

    assign arid      = rd_gnt ? arid_b    : arid_a;
    assign araddr    = rd_gnt ? araddr_b  : araddr_a;
    assign arlen     = rd_gnt ? arlen_b   : arlen_a;
    assign arsize    = rd_gnt ? arsize_b  : arsize_a;
    assign arburst   = rd_gnt ? arburst_b : arburst_a;
    assign arvalid   = rd_gnt ? arvalid_b : arvalid_a;
    assign arready_a = arready && !rd_gnt;
    assign arready_b = arready && rd_gnt;

    // read data goes back by ID, reads of both sides may overlap
    assign r_to_a      = (rid == ID_A);
    assign r_to_b      = (rid == ID_B);
    assign rvalid_a    = rvalid && r_to_a;
    assign rvalid_b    = rvalid && r_to_b;
    assign rdata_axi_a = rdata_axi;
    assign rdata_axi_b = rdata_axi;
    assign rlast_a     = rlast;
    assign rlast_b     = rlast;
    assign rready      = (r_to_a && rready_a) || (r_to_b && rready_b);

    assign awid      = wr_gnt ? awid_b      : awid_a;
    assign awaddr    = wr_gnt ? awaddr_b    : awaddr_a;
    assign awlen     = wr_gnt ? awlen_b     : awlen_a;
    assign awsize    = wr_gnt ? awsize_b    : awsize_a;
    assign awburst   = wr_gnt ? awburst_b   : awburst_a;
    assign awvalid   = wr_gnt ? awvalid_b   : awvalid_a;
    assign awready_a = awready && !wr_gnt;
    assign awready_b = awready && wr_gnt;
    assign wdata_axi = wr_gnt ? wdata_axi_b : wdata_axi_a;
    assign wstrb     = wr_gnt ? wstrb_b     : wstrb_a;
    assign wlast     = wr_gnt ? wlast_b     : wlast_a;
    assign wvalid    = wr_gnt ? wvalid_b    : wvalid_a;
    assign wready_a  = wready && !wr_gnt;
    assign wready_b  = wready && wr_gnt;

    assign bvalid_a = bvalid && wr_busy && !wr_sel;
    assign bvalid_b = bvalid && wr_busy && wr_sel;
    assign bready   = wr_busy && (wr_sel ? bready_b : bready_a);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_busy <= 1'b0;
            rd_sel  <= 1'b0;
            rd_prio <= 1'b0;
        end else if (!rd_busy && arvalid) begin
            // other side wins the next tie
            rd_prio <= !rd_gnt;
            if (!arready) begin
                rd_busy <= 1'b1;
                rd_sel  <= rd_gnt;
            end
        end else if (rd_busy && arvalid && arready) begin
            rd_busy <= 1'b0;
        end
    end

    // write grant spans AW, W and B
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_busy <= 1'b0;
            wr_sel  <= 1'b0;
            wr_prio <= 1'b0;
        end else if (!wr_busy && (awvalid || wvalid)) begin
            wr_busy <= 1'b1;
            wr_sel  <= wr_gnt;
            wr_prio <= !wr_gnt;
        end else if (bvalid && bready) begin
            wr_busy <= 1'b0;
        end
    end

endmodule

// File: source/mem_bridge_top.sv
// memory-side top with instruction and data bridges merged onto one AXI master
module mem_bridge_top #(
    parameter sramx_pkg::axi_id_t INST_ID = 4'd0,
    parameter sramx_pkg::axi_id_t DATA_ID = 4'd1
) (
    input  logic                   aclk,
    input  logic                   arst_n,

    input  logic                   inst_req,
    input  logic                   inst_wr,
    input  sramx_pkg::sram_size_t  inst_size,
    input  sramx_pkg::word_t       inst_addr,
    input  sramx_pkg::word_t       inst_wdata,
    output logic                   inst_addr_ok,
    output logic                   inst_data_ok,
    output sramx_pkg::word_t       inst_rdata,

    input  logic                   data_req,
    input  logic                   data_wr,
    input  sramx_pkg::sram_size_t  data_size,
    input  sramx_pkg::word_t       data_addr,
    input  sramx_pkg::word_t       data_wdata,
    output logic                   data_addr_ok,
    output logic                   data_data_ok,
    output sramx_pkg::word_t       data_rdata,

    output sramx_pkg::axi_id_t     arid,
    output sramx_pkg::word_t       araddr,
    output sramx_pkg::axi_len_t    arlen,
    output sramx_pkg::axi_size_t   arsize,
    output sramx_pkg::axi_burst_t  arburst,
    output logic                   arvalid,
    input  logic                   arready,
    input  sramx_pkg::axi_id_t     rid,
    input  sramx_pkg::word_t       rdata,
    input  logic                   rlast,
    input  logic                   rvalid,
    output logic                   rready,
    output sramx_pkg::axi_id_t     awid,
    output sramx_pkg::word_t       awaddr,
    output sramx_pkg::axi_len_t    awlen,
    output sramx_pkg::axi_size_t   awsize,
    output sramx_pkg::axi_burst_t  awburst,
    output logic                   awvalid,
    input  logic                   awready,
    output sramx_pkg::word_t       wdata,
    output sramx_pkg::axi_strb_t   wstrb,
    output logic                   wlast,
    output logic                   wvalid,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready
);
    // ib_ is the instruction bridge, db_ the data bridge
    sramx_pkg::axi_id_t    ib_arid, ib_awid, db_arid, db_awid;
    sramx_pkg::word_t      ib_araddr, ib_awaddr, ib_rdata, ib_wdata;
    sramx_pkg::word_t      db_araddr, db_awaddr, db_rdata, db_wdata;
    sramx_pkg::axi_len_t   ib_arlen, ib_awlen, db_arlen, db_awlen;
    sramx_pkg::axi_size_t  ib_arsize, ib_awsize, db_arsize, db_awsize;
    sramx_pkg::axi_burst_t ib_arburst, ib_awburst, db_arburst, db_awburst;
    sramx_pkg::axi_strb_t  ib_wstrb, db_wstrb;
    logic ib_arvalid, ib_arready, ib_rvalid, ib_rlast, ib_rready;
    logic ib_awvalid, ib_awready, ib_wlast, ib_wvalid, ib_wready, ib_bvalid, ib_bready;
    logic db_arvalid, db_arready, db_rvalid, db_rlast, db_rready;
    logic db_awvalid, db_awready, db_wlast, db_wvalid, db_wready, db_bvalid, db_bready;

    sramx_axi_bridge #(.AXI_ID(INST_ID)) inst_bridge (
        .clk(aclk), .arst_n(arst_n),
        .req(inst_req), .wr(inst_wr), .size(inst_size), .addr(inst_addr), .wdata(inst_wdata),
        .addr_ok(inst_addr_ok), .data_ok(inst_data_ok), .rdata(inst_rdata),
        .arid(ib_arid), .araddr(ib_araddr), .arlen(ib_arlen), .arsize(ib_arsize),
        .arburst(ib_arburst), .arvalid(ib_arvalid), .arready(ib_arready),
        .rdata_axi(ib_rdata), .rvalid(ib_rvalid), .rlast(ib_rlast), .rready(ib_rready),
        .awid(ib_awid), .awaddr(ib_awaddr), .awlen(ib_awlen), .awsize(ib_awsize),
        .awburst(ib_awburst), .awvalid(ib_awvalid), .awready(ib_awready),
        .wdata_axi(ib_wdata), .wstrb(ib_wstrb), .wlast(ib_wlast), .wvalid(ib_wvalid),
        .wready(ib_wready), .bvalid(ib_bvalid), .bready(ib_bready)
    );

    sramx_axi_bridge #(.AXI_ID(DATA_ID)) data_bridge (
        .clk(aclk), .arst_n(arst_n),
        .req(data_req), .wr(data_wr), .size(data_size), .addr(data_addr), .wdata(data_wdata),
        .addr_ok(data_addr_ok), .data_ok(data_data_ok), .rdata(data_rdata),
        .arid(db_arid), .araddr(db_araddr), .arlen(db_arlen), .arsize(db_arsize),
        .arburst(db_arburst), .arvalid(db_arvalid), .arready(db_arready),
        .rdata_axi(db_rdata), .rvalid(db_rvalid), .rlast(db_rlast), .rready(db_rready),
        .awid(db_awid), .awaddr(db_awaddr), .awlen(db_awlen), .awsize(db_awsize),
        .awburst(db_awburst), .awvalid(db_awvalid), .awready(db_awready),
        .wdata_axi(db_wdata), .wstrb(db_wstrb), .wlast(db_wlast), .wvalid(db_wvalid),
        .wready(db_wready), .bvalid(db_bvalid), .bready(db_bready)
    );

    axi_port_arbiter #(.ID_A(INST_ID), .ID_B(DATA_ID)) arbiter (
        .clk(aclk), .arst_n(arst_n),
        .arid_a(ib_arid), .araddr_a(ib_araddr), .arlen_a(ib_arlen), .arsize_a(ib_arsize),
        .arburst_a(ib_arburst), .arvalid_a(ib_arvalid), .arready_a(ib_arready),
        .rdata_axi_a(ib_rdata), .rvalid_a(ib_rvalid), .rlast_a(ib_rlast), .rready_a(ib_rready),
        .awid_a(ib_awid), .awaddr_a(ib_awaddr), .awlen_a(ib_awlen), .awsize_a(ib_awsize),
        .awburst_a(ib_awburst), .awvalid_a(ib_awvalid), .awready_a(ib_awready),
        .wdata_axi_a(ib_wdata), .wstrb_a(ib_wstrb), .wlast_a(ib_wlast),
        .wvalid_a(ib_wvalid), .wready_a(ib_wready), .bvalid_a(ib_bvalid), .bready_a(ib_bready),
        .arid_b(db_arid), .araddr_b(db_araddr), .arlen_b(db_arlen), .arsize_b(db_arsize),
        .arburst_b(db_arburst), .arvalid_b(db_arvalid), .arready_b(db_arready),
        .rdata_axi_b(db_rdata), .rvalid_b(db_rvalid), .rlast_b(db_rlast), .rready_b(db_rready),
        .awid_b(db_awid), .awaddr_b(db_awaddr), .awlen_b(db_awlen), .awsize_b(db_awsize),
        .awburst_b(db_awburst), .awvalid_b(db_awvalid), .awready_b(db_awready),
        .wdata_axi_b(db_wdata), .wstrb_b(db_wstrb), .wlast_b(db_wlast),
        .wvalid_b(db_wvalid), .wready_b(db_wready), .bvalid_b(db_bvalid), .bready_b(db_bready),
        .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .arvalid(arvalid), .arready(arready),
        .rid(rid), .rdata_axi(rdata), .rvalid(rvalid), .rlast(rlast), .rready(rready),
        .awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
        .awvalid(awvalid), .awready(awready),
        .wdata_axi(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

endmodule

// File: source/sramx_axi_bridge.sv
// SRAM-like port to single-beat AXI converter with fixed address mapping and byte strobes
module sramx_axi_bridge #(
    parameter sramx_pkg::axi_id_t AXI_ID = 4'd0
) (
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   req,
    input  logic                   wr,
    input  sramx_pkg::sram_size_t  size,
    input  sramx_pkg::word_t       addr,
    input  sramx_pkg::word_t       wdata,
    output logic                   addr_ok,
    output logic                   data_ok,
    output sramx_pkg::word_t       rdata,

    output sramx_pkg::axi_id_t     arid,
    output sramx_pkg::word_t       araddr,
    output sramx_pkg::axi_len_t    arlen,
    output sramx_pkg::axi_size_t   arsize,
    output sramx_pkg::axi_burst_t  arburst,
    output logic                   arvalid,
    input  logic                   arready,
    input  sramx_pkg::word_t       rdata_axi,
    input  logic                   rvalid,
    input  logic                   rlast,
    output logic                   rready,
    output sramx_pkg::axi_id_t     awid,
    output sramx_pkg::word_t       awaddr,
    output sramx_pkg::axi_len_t    awlen,
    output sramx_pkg::axi_size_t   awsize,
    output sramx_pkg::axi_burst_t  awburst,
    output logic                   awvalid,
    input  logic                   awready,
    output sramx_pkg::word_t       wdata_axi,
    output sramx_pkg::axi_strb_t   wstrb,
    output logic                   wlast,
    output logic                   wvalid,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready
);
    localparam int KB = sramx_pkg::KSEG_MASK_BITS;

    typedef enum logic [2:0] {
        IDLE,
        ADDR,
        WRITE,
        RESP,
        DONE
    } state_t;

    state_t                state;
    state_t                state_next;
    logic                  wr_q;
    sramx_pkg::sram_size_t size_q;
    sramx_pkg::word_t      addr_q;
    sramx_pkg::word_t      wdata_q;
    sramx_pkg::word_t      rdata_q;
    sramx_pkg::word_t      addr_phys;
    logic                  aw_done;
    logic                  w_done;
    logic                  aw_seen;
    logic                  w_seen;
    logic                  r_fire;
    logic                  b_fire;

    // kseg0/kseg1 map down to the low 512M, the rest passes
    assign addr_phys = (addr[31:30] == 2'b10) ? {{KB{1'b0}}, addr[31-KB:0]} : addr;

    assign aw_seen = aw_done || (awvalid && awready);
    assign w_seen  = w_done || (wvalid && wready);
    assign r_fire  = rvalid && rready && rlast;
    assign b_fire  = bvalid && bready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:  if (req) state_next = ADDR;
            ADDR: begin
                if (!wr_q) begin
                    if (arready) state_next = RESP;
                end else if (aw_seen && w_seen) begin
                    state_next = RESP;
                end else if (aw_seen || w_seen) begin
                    state_next = WRITE;
                end
            end
            WRITE: if (aw_seen && w_seen) state_next = RESP;
            RESP:  if (r_fire || b_fire) state_next = DONE;
            DONE:  state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state   <= state_next;
            aw_done <= (state == IDLE) ? 1'b0 : aw_seen;
            w_done  <= (state == IDLE) ? 1'b0 : w_seen;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            wr_q    <= wr;
            size_q  <= size;
            addr_q  <= addr_phys;
            wdata_q <= wdata;
        end
        if (r_fire) rdata_q <= rdata_axi;
    end

    // byte lanes from size and low address bits
    always_comb begin
        case (size_q)
            sramx_pkg::SIZE_BYTE: wstrb = 4'b0001 << addr_q[1:0];
            sramx_pkg::SIZE_HALF: wstrb = addr_q[1] ? 4'b1100 : 4'b0011;
            default:              wstrb = 4'b1111;
        endcase
    end

    assign addr_ok = (state == IDLE) && req;
    assign data_ok = (state == DONE);
    assign rdata   = rdata_q;

    assign arid    = AXI_ID;
    assign araddr  = addr_q;
    assign arlen   = sramx_pkg::AXI_LEN_SINGLE;
    assign arsize  = {1'b0, size_q};
    assign arburst = sramx_pkg::AXI_BURST_INCR;
    assign arvalid = (state == ADDR) && !wr_q;
    assign rready  = (state == RESP) && !wr_q;

    assign awid      = AXI_ID;
    assign awaddr    = addr_q;
    assign awlen     = sramx_pkg::AXI_LEN_SINGLE;
    assign awsize    = {1'b0, size_q};
    assign awburst   = sramx_pkg::AXI_BURST_INCR;
    assign awvalid   = (state == ADDR || state == WRITE) && wr_q && !aw_done;
    assign wdata_axi = wdata_q;
    assign wlast     = 1'b1;
    assign wvalid    = (state == ADDR || state == WRITE) && wr_q && !w_done;
    assign bready    = (state == RESP) && wr_q;

endmodule

// File: source/sramx_pkg.sv
// shared bus types, AXI size, burst and response codes, address mapping constants
package sramx_pkg;

    typedef logic [31:0] word_t;
    typedef logic [1:0]  sram_size_t;

    typedef logic [3:0]  axi_id_t;
    typedef logic [3:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [1:0]  axi_resp_t;

    // SRAM-like access sizes
    localparam sram_size_t SIZE_BYTE = 2'd0;
    localparam sram_size_t SIZE_HALF = 2'd1;
    localparam sram_size_t SIZE_WORD = 2'd2;

    // single beat only
    localparam axi_len_t   AXI_LEN_SINGLE = 4'd0;
    localparam axi_burst_t AXI_BURST_INCR = 2'b01;
    localparam axi_resp_t  AXI_RESP_OKAY  = 2'b00;

    // kseg0/kseg1 drop this many top bits
    localparam int KSEG_MASK_BITS = 3;

endpackage

// File: src.f
source/sramx_pkg.sv
source/sramx_axi_bridge.sv
source/axi_port_arbiter.sv
source/mem_bridge_top.sv
tests/clock_gen.sv
tests/mem_bridge_checker.sv
tests/mem_bridge_tb.sv

// File: tests/clock_gen.sv
// testbench clock and reset source
module clock_gen (
    output logic aclk,
    output logic arst_n
);
    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // reset held for 16 cycles, released away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        arst_n = 1'b1;
    end
endmodule

// File: tests/mem_bridge_checker.sv
// concurrent assertions on the AXI and SRAM-like handshakes of one bridge
module mem_bridge_checker (
    input logic clk,
    input logic arst_n,
    input logic addr_ok,
    input logic data_ok,
    input logic arvalid,
    input logic arready,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready
);
    int   fail_count = 0;
    logic busy;

    // one request outstanding from acceptance until its data_ok
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (addr_ok) begin
            busy <= 1'b1;
        end else if (data_ok) begin
            busy <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid)
        else begin
            $error("arvalid dropped before arready");
            fail_count++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before awready");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wvalid && !wready |=> wvalid)
        else begin
            $error("wvalid dropped before wready");
            fail_count++;
        end

    data_ok_busy: assert property (@(posedge clk) disable iff (!arst_n)
        data_ok |-> busy)
        else begin
            $error("data_ok without an accepted request");
            fail_count++;
        end

    addr_ok_idle: assert property (@(posedge clk) disable iff (!arst_n)
        addr_ok |-> !busy)
        else begin
            $error("addr_ok while busy");
            fail_count++;
        end
endmodule

// File: tests/mem_bridge_tb.sv
// testbench top with AXI memory model, stimulus table, checks and closing report
module mem_bridge_tb;
    localparam int NROWS = 21;
    localparam int LIMIT = NROWS * 40 + 50;
    localparam sramx_pkg::axi_id_t INST_ID = 4'd0;
    localparam sramx_pkg::axi_id_t DATA_ID = 4'd1;

    typedef struct {
        int          port;
        bit          wr;
        logic [1:0]  size;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
        bit          pair;
    } row_t;

    logic aclk;
    logic arst_n;
    logic inst_req, inst_wr, inst_addr_ok, inst_data_ok;
    logic data_req, data_wr, data_addr_ok, data_data_ok;
    sramx_pkg::sram_size_t inst_size, data_size;
    sramx_pkg::word_t inst_addr, inst_wdata, inst_rdata;
    sramx_pkg::word_t data_addr, data_wdata, data_rdata;
    sramx_pkg::axi_id_t arid, awid, rid;
    sramx_pkg::word_t araddr, awaddr, rdata, wdata;
    sramx_pkg::axi_len_t arlen, awlen;
    sramx_pkg::axi_size_t arsize, awsize;
    sramx_pkg::axi_burst_t arburst, awburst;
    sramx_pkg::axi_strb_t wstrb;
    logic arvalid, arready, rlast, rvalid, rready;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;

    row_t        rows [NROWS];
    logic [31:0] mem [256];
    logic [31:0] ref_mem [256];
    // last AR per port and last AW as seen by the memory
    logic [31:0] ar_addr_seen [2];
    logic [2:0]  ar_size_seen [2];
    logic [31:0] aw_addr_seen;
    logic [2:0]  aw_size_seen;
    logic [3:0]  aw_id_seen;
    int unsigned seed = 8100;
    int          errors = 0;
    int          cycles = 0;
    int          inst_cnt = 0;
    int          data_cnt = 0;

    clock_gen clkgen (.aclk(aclk), .arst_n(arst_n));

    mem_bridge_top #(.INST_ID(INST_ID), .DATA_ID(DATA_ID)) UUT (.*);

    bind sramx_axi_bridge mem_bridge_checker u_checker (
        .clk(clk), .arst_n(arst_n), .addr_ok(addr_ok), .data_ok(data_ok),
        .arvalid(arvalid), .arready(arready), .awvalid(awvalid), .awready(awready),
        .wvalid(wvalid), .wready(wready)
    );

    function automatic int unsigned next_delay();
        seed = seed * 32'd1103515245 + 32'd12345;
        return (seed >> 16) % 4;
    endfunction

    // kseg0/kseg1 clear the top three bits, other segments pass
    function automatic logic [31:0] phys_addr(input logic [31:0] a);
        if (a >= 32'h8000_0000 && a <= 32'hBFFF_FFFF) begin
            return a & 32'h1FFF_FFFF;
        end
        return a;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input int i, input int port, input bit wr, input logic [1:0] size,
                           input logic [31:0] addr, input logic [31:0] wd,
                           input logic [31:0] exp, input bit pair);
        rows[i] = '{port, wr, size, addr, wd, exp, pair};
    endtask

    task automatic run_op(input int i);
        row_t               r;
        logic               ok;
        logic [31:0]        got;
        logic [31:0]        pa;
        int                 k;
        sramx_pkg::axi_id_t exp_id;
        r = rows[i];
        if (r.port == 0) begin
            inst_req = 1'b1;
            inst_wr = r.wr;
            inst_size = r.size;
            inst_addr = r.addr;
            inst_wdata = r.wdata;
        end else begin
            data_req = 1'b1;
            data_wr = r.wr;
            data_size = r.size;
            data_addr = r.addr;
            data_wdata = r.wdata;
        end
        // the request is taken at the rising edge that sees addr_ok
        do begin
            @(posedge aclk);
            ok = (r.port == 0) ? inst_addr_ok : data_addr_ok;
        end while (!ok);
        @(negedge aclk);
        if (r.port == 0) inst_req = 1'b0;
        else data_req = 1'b0;
        ok = 1'b0;
        while (!ok) begin
            @(negedge aclk);
            ok = (r.port == 0) ? inst_data_ok : data_data_ok;
        end
        pa = phys_addr(r.addr);
        k = pa[9:2];
        exp_id = (r.port == 0) ? INST_ID : DATA_ID;
        if (r.wr) begin
            check_value("awaddr", aw_addr_seen, pa);
            check_value("awsize", {29'b0, aw_size_seen}, {30'b0, r.size});
            check_value("awid", {28'b0, aw_id_seen}, {28'b0, exp_id});
            // byte lane rule
            case (r.size)
                2'd0: ref_mem[k][8*r.addr[1:0] +: 8] = r.wdata[8*r.addr[1:0] +: 8];
                2'd1: ref_mem[k][16*r.addr[1] +: 16] = r.wdata[16*r.addr[1] +: 16];
                default: ref_mem[k] = r.wdata;
            endcase
        end else begin
            check_value("araddr", ar_addr_seen[r.port], pa);
            check_value("arsize", {29'b0, ar_size_seen[r.port]}, {30'b0, r.size});
            got = (r.port == 0) ? inst_rdata : data_rdata;
            check_value("ref_mem", ref_mem[k], r.exp);
            check_value(r.port == 0 ? "inst_rdata" : "data_rdata", got, ref_mem[k]);
        end
    endtask

    // AXI read slave, one transaction at a time
    initial begin
        int unsigned d;
        logic [31:0] a;
        forever begin
            @(negedge aclk);
            if (arst_n && arvalid) begin
                d = next_delay();
                repeat (d) @(negedge aclk);
                a = araddr;
                rid = arid;
                ar_addr_seen[arid[0]] = araddr;
                ar_size_seen[arid[0]] = arsize;
                check_value("arlen", {28'b0, arlen}, 32'h0);
                check_value("arburst", {30'b0, arburst}, {30'b0, sramx_pkg::AXI_BURST_INCR});
                arready = 1'b1;
                @(negedge aclk);
                arready = 1'b0;
                d = next_delay();
                repeat (d) @(negedge aclk);
                rdata = mem[a[9:2]];
                rvalid = 1'b1;
                while (!rready) @(negedge aclk);
                @(negedge aclk);
                rvalid = 1'b0;
            end
        end
    end

    // AXI write slave, takes AW and W together
    initial begin
        int unsigned d;
        forever begin
            @(negedge aclk);
            if (arst_n && awvalid && wvalid) begin
                d = next_delay();
                repeat (d) @(negedge aclk);
                aw_addr_seen = awaddr;
                aw_size_seen = awsize;
                aw_id_seen = awid;
                check_value("awlen", {28'b0, awlen}, 32'h0);
                check_value("awburst", {30'b0, awburst}, {30'b0, sramx_pkg::AXI_BURST_INCR});
                check_value("wlast", {31'b0, wlast}, 32'h1);
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) mem[awaddr[9:2]][8*b +: 8] = wdata[8*b +: 8];
                end
                awready = 1'b1;
                wready = 1'b1;
                @(negedge aclk);
                awready = 1'b0;
                wready = 1'b0;
                d = next_delay();
                repeat (d) @(negedge aclk);
                bvalid = 1'b1;
                while (!bready) @(negedge aclk);
                @(negedge aclk);
                bvalid = 1'b0;
            end
        end
    end

    always @(negedge aclk) begin
        if (arst_n && inst_data_ok) inst_cnt++;
        if (arst_n && data_data_ok) data_cnt++;
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int i;
        int inst_rows;
        int data_rows;
        int asrt;
        inst_req = 1'b0;
        inst_wr = 1'b0;
        inst_size = 2'd0;
        inst_addr = '0;
        inst_wdata = '0;
        data_req = 1'b0;
        data_wr = 1'b0;
        data_size = 2'd0;
        data_addr = '0;
        data_wdata = '0;
        arready = 1'b0;
        rid = '0;
        rdata = '0;
        rlast = 1'b1;
        rvalid = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        for (int j = 0; j < 256; j++) begin
            mem[j] = '0;
            ref_mem[j] = '0;
        end
        add_row(0,  1, 1, 2'd2, 32'h0000_0010, 32'h1122_3344, 32'h0, 0);
        add_row(1,  1, 1, 2'd2, 32'h0000_0014, 32'hAABB_CCDD, 32'h0, 0);
        add_row(2,  1, 0, 2'd2, 32'h0000_0010, 32'h0, 32'h1122_3344, 0);
        add_row(3,  1, 0, 2'd2, 32'h0000_0014, 32'h0, 32'hAABB_CCDD, 0);
        add_row(4,  1, 1, 2'd0, 32'h0000_0011, 32'hEEEE_EEEE, 32'h0, 0);
        add_row(5,  1, 1, 2'd1, 32'h0000_0016, 32'h5566_5566, 32'h0, 0);
        add_row(6,  1, 0, 2'd2, 32'h0000_0010, 32'h0, 32'h1122_EE44, 0);
        add_row(7,  1, 0, 2'd2, 32'h0000_0014, 32'h0, 32'h5566_CCDD, 0);
        add_row(8,  1, 1, 2'd2, 32'h8000_0040, 32'hCAFE_F00D, 32'h0, 0);
        add_row(9,  1, 0, 2'd2, 32'hA000_0040, 32'h0, 32'hCAFE_F00D, 0);
        add_row(10, 0, 0, 2'd2, 32'h0000_0040, 32'h0, 32'hCAFE_F00D, 0);
        add_row(11, 1, 1, 2'd2, 32'hBFC0_0020, 32'h0BAD_BEEF, 32'h0, 0);
        add_row(12, 0, 0, 2'd2, 32'h9FC0_0020, 32'h0, 32'h0BAD_BEEF, 0);
        // paired rows launch in the same cycle
        add_row(13, 0, 0, 2'd2, 32'h0000_0010, 32'h0, 32'h1122_EE44, 1);
        add_row(14, 1, 0, 2'd2, 32'h0000_0014, 32'h0, 32'h5566_CCDD, 0);
        add_row(15, 0, 0, 2'd2, 32'hBFC0_0020, 32'h0, 32'h0BAD_BEEF, 1);
        add_row(16, 1, 0, 2'd2, 32'h8000_0010, 32'h0, 32'h1122_EE44, 0);
        add_row(17, 1, 1, 2'd0, 32'h0000_0043, 32'h7777_7777, 32'h0, 0);
        add_row(18, 1, 0, 2'd2, 32'h0000_0040, 32'h0, 32'h77FE_F00D, 0);
        add_row(19, 0, 0, 2'd2, 32'h0000_0040, 32'h0, 32'h77FE_F00D, 1);
        add_row(20, 1, 0, 2'd2, 32'hA000_0014, 32'h0, 32'h5566_CCDD, 0);

        wait (arst_n === 1'b1);
        @(negedge aclk);
        check_value("arvalid", {31'b0, arvalid}, 32'h0);
        check_value("awvalid", {31'b0, awvalid}, 32'h0);
        check_value("wvalid", {31'b0, wvalid}, 32'h0);
        check_value("inst_data_ok", {31'b0, inst_data_ok}, 32'h0);
        check_value("data_data_ok", {31'b0, data_data_ok}, 32'h0);

        i = 0;
        inst_rows = 0;
        data_rows = 0;
        while (i < NROWS) begin
            @(negedge aclk);
            if (rows[i].pair) begin
                fork
                    run_op(i);
                    run_op(i + 1);
                join
                inst_rows += (rows[i].port == 0) + (rows[i + 1].port == 0);
                data_rows += (rows[i].port == 1) + (rows[i + 1].port == 1);
                i += 2;
            end else begin
                run_op(i);
                inst_rows += (rows[i].port == 0);
                data_rows += (rows[i].port == 1);
                i += 1;
            end
        end
        repeat (3) @(negedge aclk);
        check_value("inst_data_ok count", inst_cnt, inst_rows);
        check_value("data_data_ok count", data_cnt, data_rows);
        asrt = UUT.inst_bridge.u_checker.fail_count + UUT.data_bridge.u_checker.fail_count;
        $display("Done: %0d value mismatches, %0d assertion failures", errors, asrt);
        if (errors == 0 && asrt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end
endmodule
